//--- logic/mem_slot_pkg.sv
/*
 * Memory slot package
 * Shared widths, completion fault codes, the slot state encoding and the
 * timing limits of the load/store memory slot.
 */

package mem_slot_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Address width in bits, one 64 KiB space
	localparam int ADDR_W = 16;
	// Bytes carried by one bus beat
	localparam int BUS_BYTES = 8;
	// Address bits that select a byte inside one bus line
	localparam int LINE_BITS = 3;
	// Address bits below the page number, so a page is 256 bytes
	localparam int PAGE_BITS = 8;

	// Byte address of a request or a bus beat
	typedef logic [ADDR_W-1:0] addr_t;
	// One bus word, also used for the load value
	typedef logic [8*BUS_BYTES-1:0] data_t;
	// Byte enables of a single beat
	typedef logic [BUS_BYTES-1:0] sel_t;
	// Access size as log2 of the byte count, so 0 is a byte and 3 a doubleword
	typedef logic [1:0] size_t;
	// Request tag, handed back unchanged with the completion
	typedef logic [3:0] tag_t;
	// Byte offset of an access inside its line
	typedef logic [LINE_BITS-1:0] offs_t;
	// Completion status
	typedef logic [1:0] fault_t;

	// ========================================================================
	// Fault codes
	// ========================================================================

	// Normal completion
	localparam fault_t FLT_NONE = 2'd0;
	// Unaligned access that would cross a page boundary
	localparam fault_t FLT_ALN = 2'd1;
	// Bus never acknowledged the beat, all reissues used up
	localparam fault_t FLT_BUS = 2'd2;

	// Slot sequencing states
	// AVAIL waits for a request, ACTIVE has a beat on the bus,
	// DELAY sits between the low and the high beat of a split access,
	// DONE holds until the completion record has left
	typedef enum logic [1:0] {
		AVAIL,
		ACTIVE,
		DELAY,
		DONE
	} slot_state_t;

	// ========================================================================
	// Timing limits
	// ========================================================================

	// Cycles an open beat may wait for its ack before it is reissued
	localparam int BEAT_TIMEOUT = 32;
	// Reissues allowed before the op is ended with a bus error
	localparam int MAX_RETRY = 2;
	// Completion credits the consumer grants after reset
	localparam int RESULT_CREDITS = 2;

	// Counter widths that follow from the limits above
	localparam int TIMER_W = $clog2(BEAT_TIMEOUT);
	localparam int RETRY_W = $clog2(MAX_RETRY + 1);
	localparam int CREDIT_W = $clog2(RESULT_CREDITS + 1);

endpackage

//--- logic/beat_if.sv
/*
 * Beat interface
 * Per-beat status shared by the slot sequencer, the beat timer and the
 * completion former.
 */

`timescale 1ns/1ns

interface beat_if;

	// A beat is currently on the bus
	logic open;
	// First issue of a new beat, not raised again for a reissue
	logic start;
	// The open beat saw its bus ack
	logic acked;
	// The open beat is the high half of a split access
	logic hi;
	// The op ends here, on an ack or with an alignment fault and no beat
	logic last;
	// Read data of the acked beat, zero for stores
	mem_slot_pkg::data_t rdata;
	// Byte offset of the access inside its line
	mem_slot_pkg::offs_t shift;
	// Timer orders the open beat to be dropped and raised again
	logic reissue;
	// Timer gives up on the beat and ends the op
	logic bus_err;

	modport work (output open, start, acked, hi, last, rdata, shift, input reissue, bus_err);
	modport timer (input open, start, acked, output reissue, bus_err);
	modport former (input acked, hi, last, rdata, shift, bus_err);

endinterface

//--- logic/slot_work.sv
/*
 * Slot sequencer
 * Captures a load or store request, works out byte selects, beat addresses
 * and store data for one or two beats, and runs those beats on the bus.
 * A page-crossing unaligned access is never issued.
 */

`timescale 1ns/1ns

module slot_work (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                req_valid_i,
	input  mem_slot_pkg::addr_t req_addr_i,
	input  mem_slot_pkg::size_t req_size_i,
	input  logic                req_store_i,
	input  mem_slot_pkg::data_t req_data_i,
	input  logic                bus_ack_i,
	input  mem_slot_pkg::data_t bus_rdata_i,
	output logic                bus_req_o,
	output logic                bus_we_o,
	output mem_slot_pkg::addr_t bus_addr_o,
	output mem_slot_pkg::sel_t  bus_sel_o,
	output mem_slot_pkg::data_t bus_wdata_o,
	beat_if.work                beat,
	input  logic                hold_i,
	input  logic                op_done_i
);

	localparam int BB = mem_slot_pkg::BUS_BYTES;

	mem_slot_pkg::slot_state_t state_q;
	mem_slot_pkg::addr_t       addr_q;
	mem_slot_pkg::size_t       size_q;
	mem_slot_pkg::data_t       data_q;
	logic                      store_q;
	logic                      hi_q;
	logic                      req_q;

	mem_slot_pkg::addr_t cur_addr;
	mem_slot_pkg::size_t cur_size;
	mem_slot_pkg::offs_t offs;
	mem_slot_pkg::sel_t  size_mask;
	mem_slot_pkg::addr_t line_addr;
	mem_slot_pkg::addr_t next_line;
	logic [2*BB-1:0]     sel_wide;
	logic [16*BB-1:0]    wdata_wide;
	logic                split;
	logic                page_cross;
	logic                accept;
	logic                acked;
	logic                final_beat;

	// ========================================================================
	// Geometry of the access
	// ========================================================================

	// While idle the geometry is taken straight from the request, so the page
	// check is ready in the accept cycle, afterwards from the captured copy
	assign cur_addr = (state_q == mem_slot_pkg::AVAIL) ? req_addr_i : addr_q;
	assign cur_size = (state_q == mem_slot_pkg::AVAIL) ? req_size_i : size_q;
	assign offs = cur_addr[mem_slot_pkg::LINE_BITS-1:0];

	// One enable bit per byte of the access size
	always_comb begin
		case (cur_size)
			2'd0: size_mask = 8'h01;
			2'd1: size_mask = 8'h03;
			2'd2: size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	// Selects across two lines, the upper half belongs to the high beat
	assign sel_wide = {{BB{1'b0}}, size_mask} << offs;
	assign split = |sel_wide[2*BB-1:BB];

	// Store data moved to its byte lanes across the same two lines
	assign wdata_wide = {{8*BB{1'b0}}, data_q} << {offs, 3'b000};

	assign line_addr = {cur_addr[mem_slot_pkg::ADDR_W-1:mem_slot_pkg::LINE_BITS],
		{mem_slot_pkg::LINE_BITS{1'b0}}};
	assign next_line = line_addr + mem_slot_pkg::addr_t'(BB);

	// A split access whose second line sits in another page is refused
	assign page_cross = split && (next_line[mem_slot_pkg::ADDR_W-1:mem_slot_pkg::PAGE_BITS] !=
		cur_addr[mem_slot_pkg::ADDR_W-1:mem_slot_pkg::PAGE_BITS]);

	assign accept = (state_q == mem_slot_pkg::AVAIL) && req_valid_i && !hold_i;

	// An ack counts only while the request is really on the bus, which also
	// drops a late ack that lands in the reissue gap
	assign acked = req_q && bus_ack_i;
	assign final_beat = hi_q || !split;

	// ========================================================================
	// Bus and beat outputs
	// ========================================================================

	// All fields come from registers and stay put until the ack
	assign bus_req_o = req_q;
	assign bus_we_o = store_q;
	assign bus_addr_o = hi_q ? next_line : line_addr;
	assign bus_sel_o = hi_q ? sel_wide[2*BB-1:BB] : sel_wide[BB-1:0];
	assign bus_wdata_o = hi_q ? wdata_wide[16*BB-1:8*BB] : wdata_wide[8*BB-1:0];

	assign beat.open = req_q;
	// New beats start from an accepted request or from the gap before the high beat
	assign beat.start = (accept && !page_cross) || (state_q == mem_slot_pkg::DELAY);
	assign beat.acked = acked;
	assign beat.hi = hi_q;
	// Alignment faults end the op at once without any beat
	assign beat.last = (acked && final_beat) || (accept && page_cross);
	// Stores report zero so their completion carries no value
	assign beat.rdata = store_q ? '0 : bus_rdata_i;
	assign beat.shift = offs;

	// ========================================================================
	// Sequencer
	// ========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= mem_slot_pkg::AVAIL;
			req_q <= 1'b0;
			hi_q <= 1'b0;
		end else begin
			case (state_q)
				mem_slot_pkg::AVAIL: begin
					if (accept) begin
						hi_q <= 1'b0;
						if (page_cross) begin
							state_q <= mem_slot_pkg::DONE;
						end else begin
							state_q <= mem_slot_pkg::ACTIVE;
							req_q <= 1'b1;
						end
					end
				end
				mem_slot_pkg::ACTIVE: begin
					if (!req_q) begin
						// Gap cycle of a reissue, put the same beat back
						req_q <= 1'b1;
					end else if (acked) begin
						req_q <= 1'b0;
						state_q <= final_beat ? mem_slot_pkg::DONE : mem_slot_pkg::DELAY;
					end else if (beat.bus_err) begin
						// Retries used up, the high beat is never issued
						req_q <= 1'b0;
						state_q <= mem_slot_pkg::DONE;
					end else if (beat.reissue) begin
						req_q <= 1'b0;
					end
				end
				mem_slot_pkg::DELAY: begin
					hi_q <= 1'b1;
					req_q <= 1'b1;
					state_q <= mem_slot_pkg::ACTIVE;
				end
				default: begin
					// Wait for the completion record to leave the slot
					if (op_done_i) begin
						state_q <= mem_slot_pkg::AVAIL;
					end
				end
			endcase
		end
	end

	// Request payload is captured once per op
	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr_q <= req_addr_i;
			size_q <= req_size_i;
			store_q <= req_store_i;
			data_q <= req_data_i;
		end
	end

endmodule

//--- logic/beat_timer.sv
/*
 * Beat timer
 * Watches the open beat, orders a reissue when no ack arrives in time and
 * declares a bus error once the reissues are used up.
 */

`timescale 1ns/1ns

module beat_timer (
	input  logic  clk_i,
	input  logic  rst_i,
	beat_if.timer beat
);

	logic [mem_slot_pkg::TIMER_W-1:0] cnt_q;
	logic [mem_slot_pkg::RETRY_W-1:0] retry_q;
	logic                             expire;
	logic                             retries_left;

	// The beat has been on the bus for BEAT_TIMEOUT cycles with no ack
	assign expire = beat.open && !beat.acked &&
		(cnt_q == mem_slot_pkg::TIMER_W'(mem_slot_pkg::BEAT_TIMEOUT - 1));
	assign retries_left = (retry_q != mem_slot_pkg::RETRY_W'(mem_slot_pkg::MAX_RETRY));

	// Expiry turns into a reissue while retries remain, else into the verdict
	assign beat.reissue = expire && retries_left;
	assign beat.bus_err = expire && !retries_left;

	// Cycle counter
	// Start arrives one cycle before the beat goes on the bus, so the first
	// counted cycle is the first cycle with the request high
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (beat.start || beat.acked || expire) begin
			cnt_q <= '0;
		end else if (beat.open) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Retry counter, per beat
	// Each half of a split access gets its own set of reissues
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			retry_q <= '0;
		end else if (beat.start) begin
			retry_q <= '0;
		end else if (beat.reissue) begin
			retry_q <= retry_q + 1'b1;
		end
	end

endmodule

//--- logic/result_former.sv
/*
 * Completion former
 * Assembles the load value from one or two beats, extends it by size and
 * sign, attaches the fault code and sends the completion under credits.
 */

`timescale 1ns/1ns

module result_former (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 req_valid_i,
	input  mem_slot_pkg::tag_t   req_tag_i,
	input  logic                 req_signed_i,
	input  mem_slot_pkg::size_t  req_size_i,
	input  logic                 flush_i,
	input  logic                 res_credit_i,
	beat_if.former               beat,
	output logic                 res_valid_o,
	output mem_slot_pkg::tag_t   res_tag_o,
	output mem_slot_pkg::data_t  res_data_o,
	output mem_slot_pkg::fault_t res_fault_o,
	output logic                 req_credit_o,
	output logic                 hold_o,
	output logic                 op_done_o
);

	mem_slot_pkg::tag_t               tag_q;
	mem_slot_pkg::size_t              size_q;
	logic                             sgn_q;
	logic                             flushed_q;
	mem_slot_pkg::data_t              lo_q;
	logic                             pend_q;
	mem_slot_pkg::data_t              res_data_q;
	mem_slot_pkg::fault_t             res_fault_q;
	logic [mem_slot_pkg::CREDIT_W-1:0] cred_q;

	logic                 cred_nz;
	logic                 send;
	logic                 done;
	logic                 hold;
	logic                 accept;
	logic                 end_ev;
	mem_slot_pkg::data_t  merged;
	mem_slot_pkg::fault_t fault_d;

	// Cut the value down to the access size and widen it again
	function automatic mem_slot_pkg::data_t size_ext(mem_slot_pkg::data_t v,
		mem_slot_pkg::size_t sz, logic sgn);
		mem_slot_pkg::data_t r;
		case (sz)
			2'd0: r = {{56{sgn & v[7]}}, v[7:0]};
			2'd1: r = {{48{sgn & v[15]}}, v[15:0]};
			2'd2: r = {{32{sgn & v[31]}}, v[31:0]};
			default: r = v;
		endcase
		return r;
	endfunction

	// ========================================================================
	// Credit and record control
	// ========================================================================

	assign cred_nz = (cred_q != '0);
	// A flushed record is dropped, it leaves without spending a credit
	assign send = pend_q && !flushed_q && cred_nz;
	assign done = pend_q && (flushed_q || cred_nz);
	assign hold = pend_q && !done;
	assign accept = req_valid_i && !hold;
	assign end_ev = beat.last || beat.bus_err;

	assign res_valid_o = send;
	assign res_tag_o = tag_q;
	assign res_data_o = res_data_q;
	assign res_fault_o = res_fault_q;
	assign req_credit_o = done;
	assign hold_o = hold;
	assign op_done_o = done;

	// The high beat supplies the bytes above what the low beat delivered
	assign merged = beat.hi ? (lo_q | (beat.rdata << (7'd64 - {beat.shift, 3'b000}))) :
		(beat.rdata >> {beat.shift, 3'b000});

	// Bus error wins, an end with no ack is the alignment fault
	assign fault_d = beat.bus_err ? mem_slot_pkg::FLT_BUS :
		(!beat.acked ? mem_slot_pkg::FLT_ALN : mem_slot_pkg::FLT_NONE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q <= 1'b0;
			flushed_q <= 1'b0;
			cred_q <= mem_slot_pkg::CREDIT_W'(mem_slot_pkg::RESULT_CREDITS);
		end else begin
			if (end_ev) begin
				pend_q <= 1'b1;
			end else if (done) begin
				pend_q <= 1'b0;
			end
			// Flush marks the op in flight, a new op starts clean
			if (accept) begin
				flushed_q <= 1'b0;
			end else if (flush_i) begin
				flushed_q <= 1'b1;
			end
			case ({send, res_credit_i})
				2'b10: cred_q <= cred_q - 1'b1;
				2'b01: cred_q <= cred_q + 1'b1;
				default: cred_q <= cred_q;
			endcase
		end
	end

	// Op attributes, the low half of a split load and the record payload
	always_ff @(posedge clk_i) begin
		if (accept) begin
			tag_q <= req_tag_i;
			size_q <= req_size_i;
			sgn_q <= req_signed_i;
		end
		if (beat.acked && !beat.last) begin
			lo_q <= beat.rdata >> {beat.shift, 3'b000};
		end
		if (end_ev) begin
			res_fault_q <= fault_d;
			res_data_q <= (fault_d == mem_slot_pkg::FLT_NONE) ? size_ext(merged, size_q, sgn_q) : '0;
		end
	end

endmodule

//--- logic/mem_slot_top.sv
/*
 * Memory slot top level
 * One load/store slot with request and completion credit channels and a
 * 64-bit data bus, built from the sequencer, the beat timer and the
 * completion former.
 */

`timescale 1ns/1ns

module mem_slot_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 req_valid_i,
	input  mem_slot_pkg::tag_t   req_tag_i,
	input  mem_slot_pkg::addr_t  req_addr_i,
	input  mem_slot_pkg::size_t  req_size_i,
	input  logic                 req_store_i,
	input  logic                 req_signed_i,
	input  mem_slot_pkg::data_t  req_data_i,
	input  logic                 flush_i,
	input  logic                 res_credit_i,
	input  logic                 bus_ack_i,
	input  mem_slot_pkg::data_t  bus_rdata_i,
	output logic                 res_valid_o,
	output mem_slot_pkg::tag_t   res_tag_o,
	output mem_slot_pkg::data_t  res_data_o,
	output mem_slot_pkg::fault_t res_fault_o,
	output logic                 req_credit_o,
	output logic                 bus_req_o,
	output logic                 bus_we_o,
	output mem_slot_pkg::addr_t  bus_addr_o,
	output mem_slot_pkg::sel_t   bus_sel_o,
	output mem_slot_pkg::data_t  bus_wdata_o
);

	// Per-beat status shared by the three blocks
	beat_if beat ();

	// Record waiting for a completion credit
	logic hold;
	// Op has left the slot
	logic op_done;

	// ========================================================================
	// Blocks
	// ========================================================================

	slot_work slot_work_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_addr_i  (req_addr_i),
		.req_size_i  (req_size_i),
		.req_store_i (req_store_i),
		.req_data_i  (req_data_i),
		.bus_ack_i   (bus_ack_i),
		.bus_rdata_i (bus_rdata_i),
		.bus_req_o   (bus_req_o),
		.bus_we_o    (bus_we_o),
		.bus_addr_o  (bus_addr_o),
		.bus_sel_o   (bus_sel_o),
		.bus_wdata_o (bus_wdata_o),
		.beat        (beat.work),
		.hold_i      (hold),
		.op_done_i   (op_done)
	);

	// Runs beside the sequencer and watches every open beat
	beat_timer beat_timer_inst (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.beat  (beat.timer)
	);

	result_former result_former_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_valid_i  (req_valid_i),
		.req_tag_i    (req_tag_i),
		.req_signed_i (req_signed_i),
		.req_size_i   (req_size_i),
		.flush_i      (flush_i),
		.res_credit_i (res_credit_i),
		.beat         (beat.former),
		.res_valid_o  (res_valid_o),
		.res_tag_o    (res_tag_o),
		.res_data_o   (res_data_o),
		.res_fault_o  (res_fault_o),
		.req_credit_o (req_credit_o),
		.hold_o       (hold),
		.op_done_o    (op_done)
	);

endmodule

//--- verification/mem_slot_tests.svh
/*
 * Memory slot directed tests
 * Request helpers, reference models for selects and load values, and one
 * task per tested behavior of the slot.
 */

	// Moves to the drive point of the next cycle and ends one-cycle pulses
	task automatic next_cycle();
		@(posedge clk_i);
		#DRIVE_DLY;
		req_valid_i = 1'b0;
		flush_i = 1'b0;
		res_credit_i = auto_credit && (res_valid_o === 1'b1);
	endtask

	task automatic send_req(mem_slot_pkg::tag_t tag, mem_slot_pkg::addr_t addr,
		mem_slot_pkg::size_t size, logic store, logic sgn, mem_slot_pkg::data_t wdata);
		next_cycle();
		req_valid_i = 1'b1;
		req_tag_i = tag;
		req_addr_i = addr;
		req_size_i = size;
		req_store_i = store;
		req_signed_i = sgn;
		req_data_i = wdata;
	endtask

	// Returns in the cycle of the completion pulse and counts the cycles since the request in lat
	task automatic wait_result(output int lat);
		lat = 0;
		do begin
			next_cycle();
			lat++;
			if (lat > RESULT_WAIT) begin
				$display("TIMEOUT %s: no completion within %0d cycles", test_name, RESULT_WAIT);
				stop_failed();
			end
		end while (res_valid_o !== 1'b1);
		if (req_credit_o !== 1'b1) begin
			$display("ERROR %s: request credit not returned with the completion", test_name);
			stop_failed();
		end
	endtask

	task automatic wait_beats(int target);
		int n;
		n = 0;
		while (beat_addr.size() < target) begin
			next_cycle();
			n++;
			if (n > RESULT_WAIT) begin
				$display("TIMEOUT %s: bus beat never acked", test_name);
				stop_failed();
			end
		end
	endtask

	task automatic expect_quiet(int cycles);
		repeat (cycles) begin
			next_cycle();
			if (res_valid_o !== 1'b0 || req_credit_o !== 1'b0) begin
				$display("ERROR %s: slot sent a completion or credit while held", test_name);
				stop_failed();
			end
		end
	endtask

	// Runs one op to its completion and checks the returned tag
	task automatic run_op(mem_slot_pkg::tag_t tag, mem_slot_pkg::addr_t addr,
		mem_slot_pkg::size_t size, logic store, logic sgn, mem_slot_pkg::data_t wdata,
		output int b0, output int beats);
		int lat;
		b0 = beat_addr.size();
		send_req(tag, addr, size, store, sgn, wdata);
		wait_result(lat);
		check_tag("completion tag", tag, res_tag_o);
		beats = beat_addr.size() - b0;
	endtask

	// Keeps the bytes of the access size and fills the rest with sign or zero
	function automatic mem_slot_pkg::data_t extend_value(mem_slot_pkg::data_t v,
		mem_slot_pkg::size_t size, logic sgn);
		mem_slot_pkg::data_t r;
		int n;
		logic fill;
		n = 1 << size;
		fill = sgn && v[8*n-1];
		r = v;
		for (int i = n; i < 8; i++) begin
			r[8*i +: 8] = {8{fill}};
		end
		return r;
	endfunction

	// Builds the load value byte by byte from memory as the requester should see it
	function automatic mem_slot_pkg::data_t model_load(mem_slot_pkg::addr_t addr,
		mem_slot_pkg::size_t size, logic sgn);
		mem_slot_pkg::data_t v;
		for (int i = 0; i < 8; i++) begin
			v[8*i +: 8] = mem[addr + mem_slot_pkg::addr_t'(i)];
		end
		return extend_value(v, size, sgn);
	endfunction

	// Finds the selects of the low or high beat from the line that each byte falls in
	function automatic mem_slot_pkg::sel_t beat_selects(mem_slot_pkg::addr_t addr,
		mem_slot_pkg::size_t size, logic hi);
		mem_slot_pkg::sel_t s;
		mem_slot_pkg::addr_t a;
		s = '0;
		for (int i = 0; i < (1 << size); i++) begin
			a = addr + mem_slot_pkg::addr_t'(i);
			if ((a[15:3] != addr[15:3]) == hi) begin
				s[a[2:0]] = 1'b1;
			end
		end
		return s;
	endfunction

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic aligned_access();
		mem_slot_pkg::addr_t addr;
		mem_slot_pkg::data_t wdata;
		int b0;
		int beats;
		test_name = "aligned";
		// Top bit of every width is set so signed loads extend with ones
		wdata = 64'hf1e2_d3c4_b5a6_9788;
		for (int s = 0; s < 4; s++) begin
			// Offset is a multiple of the size and sits at the top of the line
			addr = mem_slot_pkg::addr_t'(16'h0100 + 16 * s + (8 - (1 << s)));
			run_op(4'(s), addr, 2'(s), 1'b1, 1'b0, wdata, b0, beats);
			check_count("store beats", 1, beats);
			check_addr("store line", {addr[15:3], 3'b000}, beat_addr[b0]);
			check_sel("store selects", beat_selects(addr, 2'(s), 1'b0), beat_sel[b0]);
			check_fault("store fault", mem_slot_pkg::FLT_NONE, res_fault_o);
			check_data("store value", '0, res_data_o);
			check_data("stored bytes", extend_value(wdata, 2'(s), 1'b0),
				model_load(addr, 2'(s), 1'b0));
			for (int sg = 0; sg < 2; sg++) begin
				run_op(4'(s + 4), addr, 2'(s), 1'b0, 1'(sg), '0, b0, beats);
				check_count("load beats", 1, beats);
				check_fault("load fault", mem_slot_pkg::FLT_NONE, res_fault_o);
				check_data("load value", extend_value(wdata, 2'(s), 1'(sg)), res_data_o);
			end
		end
	endtask

	task automatic unaligned_access();
		int b0;
		int beats;
		test_name = "unaligned";
		// Doubleword at offset 5 puts three bytes in the low beat and five in the high beat
		run_op(4'h7, 16'h0135, 2'd3, 1'b0, 1'b0, '0, b0, beats);
		check_count("load beats", 2, beats);
		check_addr("low line", 16'h0130, beat_addr[b0]);
		check_addr("high line", 16'h0138, beat_addr[b0 + 1]);
		check_sel("low selects", beat_selects(16'h0135, 2'd3, 1'b0), beat_sel[b0]);
		check_sel("high selects", beat_selects(16'h0135, 2'd3, 1'b1), beat_sel[b0 + 1]);
		check_data("merged load", model_load(16'h0135, 2'd3, 1'b0), res_data_o);
		// The upper byte of this halfword has its top bit set in memory
		run_op(4'h8, 16'h0167, 2'd1, 1'b0, 1'b1, '0, b0, beats);
		check_count("halfword beats", 2, beats);
		check_data("signed merged load", model_load(16'h0167, 2'd1, 1'b1), res_data_o);
		// A word store split over two lines lands in both
		run_op(4'h9, 16'h015e, 2'd2, 1'b1, 1'b0, 64'h1234_5678_8a7b_6c5d, b0, beats);
		check_count("split store beats", 2, beats);
		check_data("split store bytes", 64'h8a7b_6c5d, model_load(16'h015e, 2'd2, 1'b0));
	endtask

	task automatic page_cross();
		int r0;
		int lat;
		test_name = "page cross";
		r0 = rise_cyc.size();
		send_req(4'ha, 16'h02fd, 2'd2, 1'b0, 1'b0, '0);
		wait_result(lat);
		check_count("completion latency", 1, lat);
		check_tag("completion tag", 4'ha, res_tag_o);
		check_fault("completion fault", mem_slot_pkg::FLT_ALN, res_fault_o);
		check_count("bus requests", 0, rise_cyc.size() - r0);
	endtask

	task automatic beat_timeout();
		int r0;
		int f0;
		int lat;
		test_name = "timeout";
		silent = 1'b1;
		r0 = rise_cyc.size();
		f0 = fall_cyc.size();
		// A split load shows whether a high beat follows the failed low beat
		send_req(4'hb, 16'h0204, 2'd3, 1'b0, 1'b0, '0);
		wait_result(lat);
		silent = 1'b0;
		check_tag("completion tag", 4'hb, res_tag_o);
		check_fault("completion fault", mem_slot_pkg::FLT_BUS, res_fault_o);
		check_count("bus requests", mem_slot_pkg::MAX_RETRY + 1, rise_cyc.size() - r0);
		for (int i = 0; i <= mem_slot_pkg::MAX_RETRY; i++) begin
			check_count("cycles before reissue", mem_slot_pkg::BEAT_TIMEOUT,
				fall_cyc[f0 + i] - rise_cyc[r0 + i]);
			if (i < mem_slot_pkg::MAX_RETRY) begin
				check_count("drop cycles", 1, rise_cyc[r0 + i + 1] - fall_cyc[f0 + i]);
			end
		end
	endtask

	task automatic credit_flow();
		int b0;
		int beats;
		int lat;
		test_name = "credit flow";
		auto_credit = 1'b0;
		for (int i = 0; i < mem_slot_pkg::RESULT_CREDITS; i++) begin
			run_op(4'(i + 1), mem_slot_pkg::addr_t'(16'h0300 + 8 * i), 2'd3, 1'b0, 1'b0, '0,
				b0, beats);
		end
		// With the credits used up this load runs on the bus but its record waits
		b0 = beat_addr.size();
		send_req(4'hc, 16'h0318, 2'd3, 1'b0, 1'b0, '0);
		wait_beats(b0 + 1);
		expect_quiet(20);
		res_credit_i = 1'b1;
		wait_result(lat);
		check_tag("released tag", 4'hc, res_tag_o);
		check_data("released value", model_load(16'h0318, 2'd3, 1'b0), res_data_o);
		auto_credit = 1'b1;
		// Hand back the credits of the earlier completions
		repeat (mem_slot_pkg::RESULT_CREDITS) begin
			next_cycle();
			res_credit_i = 1'b1;
		end
		next_cycle();
	endtask

	task automatic flush_op();
		int b0;
		int beats;
		int n;
		test_name = "flush";
		b0 = beat_addr.size();
		send_req(4'hd, 16'h0223, 2'd3, 1'b0, 1'b0, '0);
		next_cycle();
		flush_i = 1'b1;
		n = 0;
		do begin
			next_cycle();
			n++;
			if (res_valid_o !== 1'b0) begin
				$display("ERROR %s: completion sent for a flushed load", test_name);
				stop_failed();
			end
			if (n > RESULT_WAIT) begin
				$display("TIMEOUT %s: request credit never returned", test_name);
				stop_failed();
			end
		end while (req_credit_o !== 1'b1);
		check_count("flushed load beats", 2, beat_addr.size() - b0);
		run_op(4'he, 16'h0240, 2'd2, 1'b0, 1'b1, '0, b0, beats);
		check_count("next load beats", 1, beats);
		check_fault("next load fault", mem_slot_pkg::FLT_NONE, res_fault_o);
		check_data("next load value", model_load(16'h0240, 2'd2, 1'b1), res_data_o);
	endtask

//--- verification/mem_slot_tb.sv
/*
 * Memory slot testbench
 * Runs directed load, store, fault, credit and flush tests against the slot,
 * with a byte-array model of the bus that acks after a random delay.
 */

`timescale 1ns/1ns

module mem_slot_tb;

	// Inputs change this long after the rising edge
	localparam int DRIVE_DLY = 2;
	// The bus monitor looks a little earlier, once the registers have settled
	localparam int SAMPLE_DLY = 1;
	// Longest wait for any completion or beat, in cycles
	localparam int RESULT_WAIT = 200;

	logic                 clk_i;
	logic                 rst_i;
	logic                 req_valid_i;
	mem_slot_pkg::tag_t   req_tag_i;
	mem_slot_pkg::addr_t  req_addr_i;
	mem_slot_pkg::size_t  req_size_i;
	logic                 req_store_i;
	logic                 req_signed_i;
	mem_slot_pkg::data_t  req_data_i;
	logic                 flush_i;
	logic                 res_credit_i;
	logic                 bus_ack_i;
	mem_slot_pkg::data_t  bus_rdata_i;
	logic                 res_valid_o;
	mem_slot_pkg::tag_t   res_tag_o;
	mem_slot_pkg::data_t  res_data_o;
	mem_slot_pkg::fault_t res_fault_o;
	logic                 req_credit_o;
	logic                 bus_req_o;
	logic                 bus_we_o;
	mem_slot_pkg::addr_t  bus_addr_o;
	mem_slot_pkg::sel_t   bus_sel_o;
	mem_slot_pkg::data_t  bus_wdata_o;

	// Byte-array memory behind the bus
	logic [7:0] mem [0:65535];
	// Line address and selects of every acked beat, in order
	mem_slot_pkg::addr_t beat_addr[$];
	mem_slot_pkg::sel_t  beat_sel[$];
	// Cycle numbers where bus_req_o rose and fell
	int rise_cyc[$];
	int fall_cyc[$];
	int cyc;
	logic req_prev;
	integer seed = 32'he896_174c;
	int ack_wait;
	// Silent bus never acks, used for the timeout test
	logic silent;
	// Consumer hands a completion credit straight back when set
	logic auto_credit;
	string test_name;

	mem_slot_top mem_slot_top_inst (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic stop_failed();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_data(string what, mem_slot_pkg::data_t exp, mem_slot_pkg::data_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_fault(string what, mem_slot_pkg::fault_t exp,
		mem_slot_pkg::fault_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_tag(string what, mem_slot_pkg::tag_t exp, mem_slot_pkg::tag_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_sel(string what, mem_slot_pkg::sel_t exp, mem_slot_pkg::sel_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_addr(string what, mem_slot_pkg::addr_t exp, mem_slot_pkg::addr_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_count(string what, int exp, int act);
		if (act != exp) begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	// ========================================================================
	// Bus model and monitor
	// ========================================================================

	// Completes the open beat against the byte array and raises the ack
	task automatic serve_beat();
		for (int i = 0; i < 8; i++) begin
			if (bus_we_o && bus_sel_o[i]) begin
				mem[bus_addr_o + i] = bus_wdata_o[8*i +: 8];
			end
			bus_rdata_i[8*i +: 8] = mem[bus_addr_o + i];
		end
		beat_addr.push_back(bus_addr_o);
		beat_sel.push_back(bus_sel_o);
		bus_ack_i = 1'b1;
	endtask

	initial begin
		bus_ack_i = 1'b0;
		bus_rdata_i = '0;
		ack_wait = 0;
		// Every byte gets a value mixed from both halves of its address
		for (int a = 0; a < 65536; a++) begin
			mem[a] = 8'(a) + 8'((a >> 8) * 37);
		end
		forever begin
			@(posedge clk_i);
			#DRIVE_DLY;
			if (bus_ack_i) begin
				// The ack lasts one cycle, the slot drops its request at that edge
				bus_ack_i = 1'b0;
			end else if (bus_req_o && !silent) begin
				if (ack_wait == 0) begin
					ack_wait = 1 + ({$random(seed)} % 6);
				end
				ack_wait = ack_wait - 1;
				if (ack_wait == 0) begin
					serve_beat();
				end
			end else if (!bus_req_o) begin
				ack_wait = 0;
			end
		end
	end

	// Edge log of bus_req_o, used to measure beats and reissue gaps
	initial begin
		cyc = 0;
		req_prev = 1'b0;
		forever begin
			@(posedge clk_i);
			#SAMPLE_DLY;
			cyc = cyc + 1;
			if (bus_req_o === 1'b1 && !req_prev) begin
				rise_cyc.push_back(cyc);
			end
			if (bus_req_o === 1'b0 && req_prev) begin
				fall_cyc.push_back(cyc);
			end
			req_prev = (bus_req_o === 1'b1);
		end
	end

	`include "mem_slot_tests.svh"

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		rst_i = 1'b1;
		req_valid_i = 1'b0;
		req_tag_i = '0;
		req_addr_i = '0;
		req_size_i = '0;
		req_store_i = 1'b0;
		req_signed_i = 1'b0;
		req_data_i = '0;
		flush_i = 1'b0;
		res_credit_i = 1'b0;
		silent = 1'b0;
		auto_credit = 1'b1;
		test_name = "reset";
		repeat (2) @(posedge clk_i);
		#DRIVE_DLY;
		rst_i = 1'b0;
		aligned_access();
		unaligned_access();
		page_cross();
		beat_timeout();
		credit_flow();
		flush_op();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+verification
logic/mem_slot_pkg.sv
logic/beat_if.sv
logic/slot_work.sv
logic/beat_timer.sv
logic/result_former.sv
logic/mem_slot_top.sv
verification/mem_slot_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory slot testbench with Verilator and runs it.
# The exit status is that of the simulation, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f \
	--top-module mem_slot_tb -o mem_slot_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mem_slot_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished"
exit 0
